// ==== hw/ex_pkg.sv ====
`default_nettype none

package ex_pkg;

  typedef logic [31:0] word_t;
  typedef logic [63:0] mm_t;
  typedef logic [2:0]  reg_id_t;
  typedef logic [31:0] flags_t;

  // eflags bit positions
  localparam int CF_BIT = 0;
  localparam int ZF_BIT = 6;
  localparam int SF_BIT = 7;
  localparam int OF_BIT = 11;

  typedef enum logic [1:0] {
    DS_BYTE  = 2'd0,
    DS_WORD  = 2'd1,
    DS_DWORD = 2'd2
  } datasize_e;

  typedef enum logic [2:0] {
    ALU_ADD    = 3'd0,
    ALU_SUB    = 3'd1,
    ALU_AND    = 3'd2,
    ALU_OR     = 3'd3,
    ALU_XOR    = 3'd4,
    ALU_NOT    = 3'd5,
    ALU_PASS_B = 3'd6
  } aluk_e;

  typedef enum logic [1:0] {
    SH_NONE = 2'd0,
    SH_SHL  = 2'd1,
    SH_SHR  = 2'd2,
    SH_SAR  = 2'd3
  } shift_e;

  typedef enum logic [1:0] {
    RES_ALU    = 2'd0,
    RES_SHIFT  = 2'd1,
    RES_PASS_A = 2'd2,
    RES_MM     = 2'd3
  } result_src_e;

  // decoded control word for one uop
  typedef struct packed {
    datasize_e   datasize;
    aluk_e       aluk;
    shift_e      shift_op;
    result_src_e result_src;
    logic        is_cmps_first;
    logic        is_cmps_second;
    logic        is_cmpxchg;
    logic        is_xchg;
    logic        repne_steady;
    logic        ld_gpr1;
    logic        ld_gpr2;
    logic        ld_gpr3;
    logic        dcache_write;
    logic        flags_from_alu;
  } ex_ctrl_t;

  typedef struct packed {
    logic     v;
    ex_ctrl_t ctrl;
    word_t    a;
    word_t    b;
    word_t    c;
    mm_t      mm_a;
    mm_t      mm_b;
    reg_id_t  dr1;
    reg_id_t  dr2;
    word_t    address;
  } ex_in_t;

  typedef struct packed {
    logic      v;
    datasize_e datasize;
    logic      ld_gpr1;
    logic      ld_gpr2;
    logic      dcache_write;
    logic      repne;
    word_t     result_a;
    word_t     result_b;
    word_t     result_c;
    flags_t    flags;
    mm_t       result_mm;
    reg_id_t   dr1;
    reg_id_t   dr2;
    word_t     address;
  } wb_t;

  // strobes back to decode for dependency checks
  typedef struct packed {
    logic gpr1;
    logic gpr2;
    logic gpr3;
    logic dcache_write;
  } dep_t;

  // operand mask for the active width, reserved encoding acts as dword
  function automatic word_t size_mask(datasize_e ds);
    case (ds)
      DS_BYTE: return 32'h0000_00ff;
      DS_WORD: return 32'h0000_ffff;
      default: return 32'hffff_ffff;
    endcase
  endfunction

  // index of the sign bit for the active width
  function automatic int size_msb(datasize_e ds);
    case (ds)
      DS_BYTE: return 7;
      DS_WORD: return 15;
      default: return 31;
    endcase
  endfunction

endpackage

`default_nettype wire

// ==== hw/operand_select_ex.sv ====
`timescale 1ns/1ns
`default_nettype none

module operand_select_ex
  import ex_pkg::*;
(
  input  wire    clk,
  input  wire    rst,
  input  ex_in_t ex,
  input  word_t  count_fwd,
  output word_t  alu_a,
  output word_t  alu_b,
  output word_t  count
);

  // first cmps operand, held until the second uop arrives
  word_t cmps_first_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      cmps_first_q <= '0;
    end else if (ex.v && ex.ctrl.is_cmps_first) begin
      cmps_first_q <= ex.a;
    end
  end

  always_comb begin
    if (ex.ctrl.is_cmps_second) begin
      // second string element also arrives on a
      alu_a = cmps_first_q;
      alu_b = ex.a;
    end else begin
      alu_a = ex.a;
      alu_b = ex.b;
    end
  end

  // repne loops use the forwarded count, otherwise ecx from c
  assign count = ex.ctrl.repne_steady ? count_fwd : ex.c;

endmodule

`default_nettype wire

// ==== hw/functional_unit_ex.sv ====
`timescale 1ns/1ns
`default_nettype none

module functional_unit_ex
  import ex_pkg::*;
(
  input  ex_ctrl_t   ctrl,
  input  word_t      alu_a,
  input  word_t      alu_b,
  input  word_t      shift_src,
  input  logic [4:0] shift_amt,
  input  word_t      count,
  input  mm_t        mm_a,
  input  mm_t        mm_b,
  input  flags_t     flags_fwd,
  output word_t      alu_result,
  output flags_t     alu_flags,
  output word_t      shift_result,
  output flags_t     shift_flags,
  output mm_t        mm_result,
  output word_t      count_dec
);

  always_comb begin : alu
    word_t       mask;
    int          msb;
    aluk_e       op;
    word_t       am;
    word_t       bm;
    logic [32:0] raw;
    logic        sa;
    logic        sb;
    logic        sr;
    mask = size_mask(ctrl.datasize);
    msb  = size_msb(ctrl.datasize);
    // compares always subtract
    op = (ctrl.is_cmps_second || ctrl.is_cmpxchg) ? ALU_SUB : ctrl.aluk;
    am = alu_a & mask;
    bm = alu_b & mask;
    case (op)
      ALU_ADD:    raw = {1'b0, am} + {1'b0, bm};
      ALU_SUB:    raw = {1'b0, am} - {1'b0, bm};
      ALU_AND:    raw = {1'b0, am & bm};
      ALU_OR:     raw = {1'b0, am | bm};
      ALU_XOR:    raw = {1'b0, am ^ bm};
      ALU_NOT:    raw = {1'b0, ~am};
      ALU_PASS_B: raw = {1'b0, bm};
      default:    raw = '0;
    endcase
    alu_result = raw[31:0] & mask;
    sa = am[msb];
    sb = bm[msb];
    sr = alu_result[msb];
    alu_flags = flags_fwd;
    // carry or borrow lands just above the width since operands are masked
    alu_flags[CF_BIT] = (op == ALU_ADD || op == ALU_SUB) ? raw[msb+1] : 1'b0;
    alu_flags[ZF_BIT] = (alu_result == '0);
    alu_flags[SF_BIT] = sr;
    case (op)
      ALU_ADD: alu_flags[OF_BIT] = (sa == sb) && (sr != sa);
      ALU_SUB: alu_flags[OF_BIT] = (sa != sb) && (sr != sa);
      default: alu_flags[OF_BIT] = 1'b0;
    endcase
  end

  always_comb begin : shifter
    word_t       mask;
    int          msb;
    word_t       src_m;
    word_t       src_sx;
    logic [63:0] ext;
    logic        cf;
    mask   = size_mask(ctrl.datasize);
    msb    = size_msb(ctrl.datasize);
    src_m  = shift_src & mask;
    src_sx = src_m | (shift_src[msb] ? ~mask : '0);
    // right shifts keep the last bit out in ext[31]
    case (ctrl.shift_op)
      SH_SHL:  ext = {32'b0, src_m} << shift_amt;
      SH_SHR:  ext = {src_m, 32'b0} >> shift_amt;
      SH_SAR:  ext = $signed({src_sx, 32'b0}) >>> shift_amt;
      default: ext = {32'b0, src_m};
    endcase
    if (ctrl.shift_op == SH_SHR || ctrl.shift_op == SH_SAR) begin
      shift_result = ext[63:32] & mask;
      cf = ext[31];
    end else begin
      shift_result = ext[31:0] & mask;
      cf = ext[msb+1];
    end
    shift_flags = flags_fwd;
    // a zero count leaves every flag alone
    if (shift_amt != '0 && ctrl.shift_op != SH_NONE) begin
      shift_flags[CF_BIT] = cf;
      shift_flags[ZF_BIT] = (shift_result == '0);
      shift_flags[SF_BIT] = shift_result[msb];
      case (ctrl.shift_op)
        SH_SHL:  shift_flags[OF_BIT] = shift_result[msb] ^ cf;
        SH_SHR:  shift_flags[OF_BIT] = src_m[msb];
        default: shift_flags[OF_BIT] = 1'b0;
      endcase
    end
  end

  // paddw, four lanes, no carry between lanes
  always_comb begin : mmx_add
    for (int i = 0; i < 4; i++) begin
      mm_result[16*i +: 16] = mm_a[16*i +: 16] + mm_b[16*i +: 16];
    end
  end

  assign count_dec = count - 32'd1;

endmodule

`default_nettype wire

// ==== hw/cmpxchg_decision_ex.sv ====
`timescale 1ns/1ns
`default_nettype none

module cmpxchg_decision_ex
  import ex_pkg::*;
(
  input  ex_ctrl_t ctrl,
  input  flags_t   alu_flags,
  output logic     ld_gpr1,
  output logic     ld_gpr2,
  output logic     dcache_write
);

  logic equal;

  assign equal = alu_flags[ZF_BIT];

  always_comb begin
    ld_gpr2 = ctrl.ld_gpr2;
    if (ctrl.is_cmpxchg) begin
      // match stores the source, mismatch loads eax with the destination
      dcache_write = equal;
      ld_gpr1      = !equal;
    end else begin
      dcache_write = ctrl.dcache_write;
      ld_gpr1      = ctrl.ld_gpr1;
    end
  end

endmodule

`default_nettype wire

// ==== hw/result_select_ex.sv ====
`timescale 1ns/1ns
`default_nettype none

module result_select_ex
  import ex_pkg::*;
(
  input  ex_ctrl_t ctrl,
  input  word_t    a,
  input  word_t    b,
  input  word_t    c,
  input  word_t    count_dec,
  input  word_t    alu_result,
  input  flags_t   alu_flags,
  input  word_t    shift_result,
  input  flags_t   shift_flags,
  input  mm_t      mm_result,
  input  flags_t   flags_fwd,
  output word_t    result_a,
  output word_t    result_b,
  output word_t    result_c,
  output flags_t   flags,
  output mm_t      result_mm
);

  word_t unit_out;

  always_comb begin
    case (ctrl.result_src)
      RES_ALU:    unit_out = alu_result;
      RES_SHIFT:  unit_out = shift_result;
      RES_PASS_A: unit_out = a;
      default:    unit_out = mm_result[31:0];
    endcase
  end

  // xchg swaps the two operands
  always_comb begin
    if (ctrl.is_xchg) begin
      result_a = b;
      result_b = a;
    end else begin
      result_a = unit_out;
      result_b = b;
    end
  end

  always_comb begin
    if (ctrl.flags_from_alu) begin
      flags = alu_flags;
    end else if (ctrl.shift_op != SH_NONE) begin
      flags = shift_flags;
    end else begin
      flags = flags_fwd;
    end
  end

  assign result_c  = ctrl.repne_steady ? count_dec : c;
  assign result_mm = mm_result;

endmodule

`default_nettype wire

// ==== hw/execute.sv ====
`timescale 1ns/1ns
`default_nettype none

module execute
  import ex_pkg::*;
(
  input  wire    clk,
  input  wire    rst,
  input  ex_in_t ex,
  input  flags_t flags_fwd,
  input  word_t  count_fwd,
  output wb_t    wb_next,
  output dep_t   dep
);

  word_t  alu_a;
  word_t  alu_b;
  word_t  count;
  word_t  alu_result;
  flags_t alu_flags;
  word_t  shift_result;
  flags_t shift_flags;
  mm_t    mm_result;
  word_t  count_dec;
  logic   ld_gpr1;
  logic   ld_gpr2;
  logic   dcache_write;
  word_t  result_a;
  word_t  result_b;
  word_t  result_c;
  flags_t flags;
  mm_t    result_mm;

  operand_select_ex u_operand_select_ex (
    .clk       (clk),
    .rst       (rst),
    .ex        (ex),
    .count_fwd (count_fwd),
    .alu_a     (alu_a),
    .alu_b     (alu_b),
    .count     (count)
  );

  functional_unit_ex u_functional_unit_ex (
    .ctrl         (ex.ctrl),
    .alu_a        (alu_a),
    .alu_b        (alu_b),
    .shift_src    (ex.a),
    .shift_amt    (ex.c[4:0]),
    .count        (count),
    .mm_a         (ex.mm_a),
    .mm_b         (ex.mm_b),
    .flags_fwd    (flags_fwd),
    .alu_result   (alu_result),
    .alu_flags    (alu_flags),
    .shift_result (shift_result),
    .shift_flags  (shift_flags),
    .mm_result    (mm_result),
    .count_dec    (count_dec)
  );

  cmpxchg_decision_ex u_cmpxchg_decision_ex (
    .ctrl         (ex.ctrl),
    .alu_flags    (alu_flags),
    .ld_gpr1      (ld_gpr1),
    .ld_gpr2      (ld_gpr2),
    .dcache_write (dcache_write)
  );

  result_select_ex u_result_select_ex (
    .ctrl         (ex.ctrl),
    .a            (ex.a),
    .b            (ex.b),
    .c            (ex.c),
    .count_dec    (count_dec),
    .alu_result   (alu_result),
    .alu_flags    (alu_flags),
    .shift_result (shift_result),
    .shift_flags  (shift_flags),
    .mm_result    (mm_result),
    .flags_fwd    (flags_fwd),
    .result_a     (result_a),
    .result_b     (result_b),
    .result_c     (result_c),
    .flags        (flags),
    .result_mm    (result_mm)
  );

  // decode only sees strobes from a valid uop
  assign dep.gpr1         = ex.v & ld_gpr1;
  assign dep.gpr2         = ex.v & ld_gpr2;
  assign dep.gpr3         = ex.v & ex.ctrl.ld_gpr3;
  assign dep.dcache_write = ex.v & dcache_write;

  always_comb begin
    wb_next.v            = ex.v;
    wb_next.datasize     = ex.ctrl.datasize;
    wb_next.ld_gpr1      = ld_gpr1;
    wb_next.ld_gpr2      = ld_gpr2;
    wb_next.dcache_write = dcache_write;
    wb_next.repne        = ex.ctrl.repne_steady;
    wb_next.result_a     = result_a;
    wb_next.result_b     = result_b;
    wb_next.result_c     = result_c;
    wb_next.flags        = flags;
    wb_next.result_mm    = result_mm;
    wb_next.dr1          = ex.dr1;
    wb_next.dr2          = ex.dr2;
    wb_next.address      = ex.address;
  end

endmodule

`default_nettype wire

// ==== hw/ex_wb_latch.sv ====
`timescale 1ns/1ns
`default_nettype none

module ex_wb_latch
  import ex_pkg::*;
(
  input  wire  clk,
  input  wire  rst,
  input  wb_t  wb_next,
  input  logic wb_stall,
  input  logic repne_terminate,
  input  logic repne_steady,
  output wb_t  wb,
  output logic ld_latches
);

  wb_t  wb_q;
  logic v_q;
  logic ld_gpr1_q;
  logic ld_gpr2_q;
  logic dcache_write_q;
  logic repne_q;
  logic squash;

  assign ld_latches = ~wb_stall;

  // terminated repne iteration turns into a bubble
  assign squash = repne_steady & repne_terminate;

  always_ff @(posedge clk) begin
    if (ld_latches) begin
      wb_q <= wb_next;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      v_q            <= 1'b0;
      ld_gpr1_q      <= 1'b0;
      ld_gpr2_q      <= 1'b0;
      dcache_write_q <= 1'b0;
      repne_q        <= 1'b0;
    end else if (ld_latches) begin
      v_q            <= wb_next.v & ~squash;
      ld_gpr1_q      <= wb_next.ld_gpr1;
      ld_gpr2_q      <= wb_next.ld_gpr2;
      dcache_write_q <= wb_next.dcache_write;
      repne_q        <= wb_next.repne;
    end
  end

  always_comb begin
    wb              = wb_q;
    wb.v            = v_q;
    wb.ld_gpr1      = ld_gpr1_q;
    wb.ld_gpr2      = ld_gpr2_q;
    wb.dcache_write = dcache_write_q;
    wb.repne        = repne_q;
  end

endmodule

`default_nettype wire

// ==== hw/execute_pipe_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module execute_pipe_top
  import ex_pkg::*;
(
  input  wire    clk,
  input  wire    rst,
  input  ex_in_t ex,
  input  flags_t flags_fwd,
  input  word_t  count_fwd,
  input  logic   wb_stall,
  input  logic   repne_terminate,
  output wb_t    wb,
  output dep_t   dep,
  output logic   ld_latches
);

  wb_t wb_next;

  execute u_execute (
    .clk       (clk),
    .rst       (rst),
    .ex        (ex),
    .flags_fwd (flags_fwd),
    .count_fwd (count_fwd),
    .wb_next   (wb_next),
    .dep       (dep)
  );

  ex_wb_latch u_ex_wb_latch (
    .clk             (clk),
    .rst             (rst),
    .wb_next         (wb_next),
    .wb_stall        (wb_stall),
    .repne_terminate (repne_terminate),
    .repne_steady    (ex.ctrl.repne_steady),
    .wb              (wb),
    .ld_latches      (ld_latches)
  );

endmodule

`default_nettype wire

// ==== test/execute_properties.sv ====
`timescale 1ns/1ns
`default_nettype none

module execute_properties
  import ex_pkg::*;
(
  input wire  clk,
  input wire  rst,
  input logic ex_v,
  input logic wb_stall,
  input wb_t  wb,
  input dep_t dep
);

  // the stage comes out of reset empty
  property valid_clear_after_reset;
    @(posedge clk) rst |=> !wb.v;
  endproperty

  property wb_held_under_stall;
    @(posedge clk) disable iff (rst) wb_stall |=> $stable(wb);
  endproperty

  property dep_quiet_when_invalid;
    @(posedge clk) !ex_v |-> (dep == '0);
  endproperty

  assert property (valid_clear_after_reset)
    else $error("wb.v set in the cycle after reset");
  assert property (wb_held_under_stall)
    else $error("wb changed while wb_stall was high");
  assert property (dep_quiet_when_invalid)
    else $error("dep strobe active for an invalid uop");

endmodule

bind execute_pipe_top execute_properties u_execute_properties (
  .clk      (clk),
  .rst      (rst),
  .ex_v     (ex.v),
  .wb_stall (wb_stall),
  .wb       (wb),
  .dep      (dep)
);

`default_nettype wire

// ==== test/execute_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module execute_tb
  import ex_pkg::*;
();

  localparam int NUM_RANDOM   = 400;
  localparam int NUM_DIRECTED = 19;
  // all vectors at one per 8 ns clock plus reset and drain slack
  localparam int TIMEOUT_NS   = (5 + NUM_DIRECTED + NUM_RANDOM + 10) * 8 + 400;

  logic   clk = 1'b0;
  logic   rst;
  ex_in_t ex;
  flags_t flags_fwd;
  word_t  count_fwd;
  logic   wb_stall;
  logic   repne_terminate;
  wb_t    wb;
  dep_t   dep;
  logic   ld_latches;
  word_t  lcg_state = 32'd6;

  execute_pipe_top dut0 (
    .clk             (clk),
    .rst             (rst),
    .ex              (ex),
    .flags_fwd       (flags_fwd),
    .count_fwd       (count_fwd),
    .wb_stall        (wb_stall),
    .repne_terminate (repne_terminate),
    .wb              (wb),
    .dep             (dep),
    .ld_latches      (ld_latches)
  );

  always #4 clk = ~clk;

  function automatic word_t rnd();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    // fold high bits down since low lcg bits repeat quickly
    return lcg_state ^ (lcg_state >> 16);
  endfunction

  function automatic ex_in_t rand_uop();
    ex_in_t u;
    word_t  r;
    u = '0;
    r = rnd();
    u.v                   = r[0] | r[1];
    u.ctrl.datasize       = (r[3:2] == 2'd3) ? DS_DWORD : datasize_e'(r[3:2]);
    u.ctrl.aluk           = (r[12:10] == 3'd7) ? ALU_ADD : aluk_e'(r[12:10]);
    u.ctrl.shift_op       = shift_e'(r[19:18]);
    u.ctrl.result_src     = result_src_e'(r[21:20]);
    u.ctrl.is_xchg        = (r[24:22] == 3'd0);
    u.ctrl.repne_steady   = (r[26:25] == 2'd0);
    u.ctrl.ld_gpr1        = r[27];
    u.ctrl.ld_gpr2        = r[28];
    u.ctrl.ld_gpr3        = r[29];
    u.ctrl.dcache_write   = r[30];
    u.ctrl.flags_from_alu = r[31];
    u.a = rnd();
    u.b = (r[15:14] == 2'd0) ? u.a : rnd();
    u.c = rnd();
    // zero shift counts show up often
    if (u.c[9:8] == 2'd0) begin
      u.c[4:0] = 5'd0;
    end
    u.mm_a    = {rnd(), rnd()};
    u.mm_b    = {rnd(), rnd()};
    u.dr1     = r[7:5];
    u.dr2     = r[17:15];
    u.address = rnd();
    return u;
  endfunction

  // expected writeback word from the x86 flag and result rules
  function automatic wb_t ref_wb(ex_in_t u, flags_t ff, word_t cnt, word_t cmps_q);
    wb_t                w;
    int                 n;
    word_t              m;
    word_t              x;
    word_t              y;
    word_t              ar;
    word_t              src;
    word_t              sr;
    word_t              sx;
    logic signed [31:0] st;
    flags_t             af;
    flags_t             sf;
    logic               sub;
    logic               cf;
    logic               of;
    logic [4:0]         amt;
    w = '0;
    n = (u.ctrl.datasize == DS_BYTE) ? 8 : ((u.ctrl.datasize == DS_WORD) ? 16 : 32);
    m = 32'hffff_ffff >> (32 - n);
    x = (u.ctrl.is_cmps_second ? cmps_q : u.a) & m;
    y = (u.ctrl.is_cmps_second ? u.a : u.b) & m;
    sub = u.ctrl.is_cmps_second || u.ctrl.is_cmpxchg || (u.ctrl.aluk == ALU_SUB);
    af = ff;
    af[CF_BIT] = 1'b0;
    af[OF_BIT] = 1'b0;
    if (sub) begin
      ar = (x - y) & m;
      af[CF_BIT] = (x < y);
      af[OF_BIT] = (x[n-1] != y[n-1]) && (ar[n-1] != x[n-1]);
    end else begin
      case (u.ctrl.aluk)
        ALU_ADD: begin
          ar = (x + y) & m;
          af[CF_BIT] = ({1'b0, x} + {1'b0, y}) > {1'b0, m};
          af[OF_BIT] = (x[n-1] == y[n-1]) && (ar[n-1] != x[n-1]);
        end
        ALU_AND:    ar = x & y;
        ALU_OR:     ar = x | y;
        ALU_XOR:    ar = x ^ y;
        ALU_NOT:    ar = ~x & m;
        ALU_PASS_B: ar = y;
        default:    ar = '0;
      endcase
    end
    af[ZF_BIT] = (ar == '0);
    af[SF_BIT] = ar[n-1];

    amt = u.c[4:0];
    src = u.a & m;
    cf  = 1'b0;
    of  = 1'b0;
    case (u.ctrl.shift_op)
      SH_SHL: begin
        sr = (src << amt) & m;
        cf = (amt != 5'd0 && int'(amt) <= n) ? src[n - int'(amt)] : 1'b0;
        of = sr[n-1] ^ cf;
      end
      SH_SHR: begin
        sr = src >> amt;
        cf = (amt != 5'd0) ? src[int'(amt) - 1] : 1'b0;
        of = src[n-1];
      end
      SH_SAR: begin
        sx = src | (src[n-1] ? ~m : '0);
        st = $signed(sx) >>> amt;
        sr = st & m;
        cf = (amt != 5'd0) ? sx[int'(amt) - 1] : 1'b0;
      end
      default: sr = src;
    endcase
    sf = ff;
    if (amt != 5'd0 && u.ctrl.shift_op != SH_NONE) begin
      sf[CF_BIT] = cf;
      sf[ZF_BIT] = (sr == '0);
      sf[SF_BIT] = sr[n-1];
      sf[OF_BIT] = of;
    end

    // paddw where each lane wraps on its own
    for (int i = 0; i < 4; i++) begin
      w.result_mm[16*i +: 16] = u.mm_a[16*i +: 16] + u.mm_b[16*i +: 16];
    end
    if (u.ctrl.is_xchg) begin
      w.result_a = u.b;
      w.result_b = u.a;
    end else begin
      w.result_b = u.b;
      case (u.ctrl.result_src)
        RES_ALU:    w.result_a = ar;
        RES_SHIFT:  w.result_a = sr;
        RES_PASS_A: w.result_a = u.a;
        default:    w.result_a = w.result_mm[31:0];
      endcase
    end
    if (u.ctrl.flags_from_alu) begin
      w.flags = af;
    end else if (u.ctrl.shift_op != SH_NONE) begin
      w.flags = sf;
    end else begin
      w.flags = ff;
    end
    w.result_c = u.ctrl.repne_steady ? cnt - 32'd1 : u.c;
    if (u.ctrl.is_cmpxchg) begin
      w.dcache_write = af[ZF_BIT];
      w.ld_gpr1      = !af[ZF_BIT];
    end else begin
      w.dcache_write = u.ctrl.dcache_write;
      w.ld_gpr1      = u.ctrl.ld_gpr1;
    end
    w.ld_gpr2  = u.ctrl.ld_gpr2;
    w.v        = u.v;
    w.datasize = u.ctrl.datasize;
    w.repne    = u.ctrl.repne_steady;
    w.dr1      = u.dr1;
    w.dr2      = u.dr2;
    w.address  = u.address;
    return w;
  endfunction

  function automatic dep_t ref_dep(ex_in_t u, wb_t w);
    dep_t d;
    d.gpr1         = u.v & w.ld_gpr1;
    d.gpr2         = u.v & w.ld_gpr2;
    d.gpr3         = u.v & u.ctrl.ld_gpr3;
    d.dcache_write = u.v & w.dcache_write;
    return d;
  endfunction

  task automatic compare_field(string name, logic [255:0] exp, logic [255:0] got);
    assert (got === exp) else begin
      $display("ERR %s expected %h actual %h", name, exp, got);
      $display("TEST FAILED");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  task automatic launch(ex_in_t u, logic stall, logic term);
    @(posedge clk);
    #1;
    ex              = u;
    wb_stall        = stall;
    repne_terminate = term;
    flags_fwd       = rnd();
    count_fwd       = rnd();
  endtask

  // outputs are settled at the falling edge
  initial begin : compare
    wb_t   exp_wb;
    wb_t   nxt;
    dep_t  exp_dep;
    word_t cmps_q;
    logic  armed;
    armed  = 1'b0;
    cmps_q = '0;
    exp_wb = '0;
    forever begin
      @(negedge clk);
      nxt     = ref_wb(ex, flags_fwd, count_fwd, cmps_q);
      exp_dep = ref_dep(ex, nxt);
      if (armed) begin
        compare_field("wb.v", 256'(exp_wb.v), 256'(wb.v));
        compare_field("wb.result_a", 256'(exp_wb.result_a), 256'(wb.result_a));
        compare_field("wb.flags", 256'(exp_wb.flags), 256'(wb.flags));
        compare_field("wb", 256'(exp_wb), 256'(wb));
        compare_field("dep", 256'(exp_dep), 256'(dep));
        compare_field("ld_latches", 256'(!wb_stall), 256'(ld_latches));
      end
      if (rst) begin
        nxt.v            = 1'b0;
        nxt.ld_gpr1      = 1'b0;
        nxt.ld_gpr2      = 1'b0;
        nxt.dcache_write = 1'b0;
        nxt.repne        = 1'b0;
        exp_wb           = nxt;
        cmps_q           = '0;
      end else begin
        if (!wb_stall) begin
          // terminated repne iteration becomes a bubble
          if (ex.ctrl.repne_steady && repne_terminate) begin
            nxt.v = 1'b0;
          end
          exp_wb = nxt;
        end
        if (ex.v && ex.ctrl.is_cmps_first) begin
          cmps_q = ex.a;
        end
      end
      armed = 1'b1;
    end
  end

  initial begin : watchdog
    #(TIMEOUT_NS);
    $display("timeout: the stimulus did not finish in the expected time");
    $display("TEST FAILED");
    $fatal(1, "watchdog expired");
  end

  initial begin : stimulus
    ex_in_t u;
    word_t  first;
    word_t  r;
    rst             = 1'b1;
    ex              = '0;
    flags_fwd       = '0;
    count_fwd       = '0;
    wb_stall        = 1'b0;
    repne_terminate = 1'b0;
    repeat (5) @(posedge clk);
    #1;
    rst = 1'b0;

    // cmps pairs with an unrelated uop in between for equal then unequal
    for (int k = 0; k < 2; k++) begin
      u = rand_uop();
      u.v = 1'b1;
      u.ctrl.is_cmps_first = 1'b1;
      first = u.a;
      launch(u, 1'b0, 1'b0);
      u = rand_uop();
      u.v = 1'b1;
      launch(u, 1'b0, 1'b0);
      u = rand_uop();
      u.v = 1'b1;
      u.ctrl.is_cmps_second = 1'b1;
      u.ctrl.flags_from_alu = 1'b1;
      u.ctrl.is_xchg        = 1'b0;
      u.ctrl.result_src     = RES_ALU;
      u.a = (k == 0) ? first : first ^ 32'h1;
      launch(u, 1'b0, 1'b0);
    end

    // cmpxchg valid and not valid with equal and unequal operands
    for (int k = 0; k < 4; k++) begin
      u = rand_uop();
      u.v = (k < 2);
      u.ctrl.is_cmpxchg = 1'b1;
      u.b = (k % 2 == 0) ? u.a : u.a ^ 32'h1;
      launch(u, 1'b0, 1'b0);
    end

    // repne steady with and without terminate
    for (int k = 0; k < 4; k++) begin
      u = rand_uop();
      u.v = 1'b1;
      u.ctrl.repne_steady = 1'b1;
      launch(u, 1'b0, k[0]);
    end

    // mmx lanes near the wrap point
    for (int k = 0; k < 4; k++) begin
      u = rand_uop();
      u.v = 1'b1;
      u.ctrl.is_xchg    = 1'b0;
      u.ctrl.result_src = RES_MM;
      u.mm_a = (k < 2) ? 64'hffff_8000_7fff_0001 : u.mm_a;
      u.mm_b = (k == 0) ? 64'h0001_8000_0001_ffff : u.mm_b;
      launch(u, 1'b0, 1'b0);
    end

    for (int k = 0; k < NUM_RANDOM; k++) begin
      u = rand_uop();
      r = rnd();
      launch(u, r[1:0] == 2'd0, r[2]);
    end

    launch('0, 1'b0, 1'b0);
    repeat (2) @(negedge clk);
    #1;
    $display("TEST PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== execute_pipe.f ====
hw/ex_pkg.sv
hw/operand_select_ex.sv
hw/functional_unit_ex.sv
hw/cmpxchg_decision_ex.sv
hw/result_select_ex.sv
hw/execute.sv
hw/ex_wb_latch.sv
hw/execute_pipe_top.sv
test/execute_properties.sv
test/execute_tb.sv

// ==== Makefile ====
# Verilator simulation of the execute stage

VERILATOR ?= verilator
TOP       ?= execute_tb
FILELIST  ?= execute_pipe.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ns

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi
	@if ! grep -q "TEST PASSED" $(LOG); then \
		echo "simulation ended without a result, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
